//--- build.f
+incdir+.
cpu_pkg.sv
cpu_ifs.sv
fetch_stage.sv
regfile.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
cpu_core.sv
tb_cpu_core.sv

//--- cpu_core.sv
`timescale 1ns/1ns

module cpu_core import cpu_pkg::*; (
    input  logic            cpu_clk,
    input  logic            rst_i,
    output logic [XLEN-1:0] pc_o,
    input  logic [XLEN-1:0] inst_i,
    output logic [XLEN-1:0] dmem_addr_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    output logic            dmem_we_o,
    input  logic [XLEN-1:0] dmem_rdata_i
);

    logic                  stall, redirect;
    logic [XLEN-1:0]       redirect_pc;
    logic                  if_valid;
    logic [XLEN-1:0]       if_pc, if_inst;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();

    fetch_stage fetch_stage_inst (
        .cpu_clk       (cpu_clk),
        .rst_i         (rst_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_i        (inst_i),
        .pc_o          (pc_o),
        .if_valid_o    (if_valid),
        .if_pc_o       (if_pc),
        .if_inst_o     (if_inst)
    );

    decode_stage decode_stage_inst (
        .cpu_clk    (cpu_clk),
        .rst_i      (rst_i),
        .if_valid_i (if_valid),
        .if_pc_i    (if_pc),
        .if_inst_i  (if_inst),
        .flush_i    (redirect),
        .wb_we_i    (wb_we),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .stall_o    (stall),
        .id_ex      (id_ex_bus.src)
    );

    execute_stage execute_stage_inst (
        .cpu_clk       (cpu_clk),
        .rst_i         (rst_i),
        .id_ex         (id_ex_bus.dst),
        .wb_we_i       (wb_we),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .ex_mem        (ex_mem_bus.src)
    );

    mem_wb_stage mem_wb_stage_inst (
        .cpu_clk      (cpu_clk),
        .rst_i        (rst_i),
        .ex_mem       (ex_mem_bus.dst),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_we_o      (wb_we),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

endmodule

//--- cpu_ifs.sv
`timescale 1ns/1ns

interface id_ex_if import cpu_pkg::*; ();
    logic                  valid;
    logic [XLEN-1:0]       pc, pc_plus4;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]       rs1_data, rs2_data;
    logic [XLEN-1:0]       imm;
    logic [2:0]            alu_op;
    logic                  alu_src_imm;
    logic                  reg_write, mem_write;
    logic [1:0]            result_sel;
    logic                  is_branch, branch_ne, is_jal;

    modport src (output valid, pc, pc_plus4, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
                 alu_src_imm, reg_write, mem_write, result_sel, is_branch, branch_ne, is_jal);
    modport dst (input valid, pc, pc_plus4, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
                 alu_src_imm, reg_write, mem_write, result_sel, is_branch, branch_ne, is_jal);
endinterface

interface ex_mem_if import cpu_pkg::*; ();
    logic                  reg_write, mem_write;
    logic [1:0]            result_sel;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       alu_res, store_data, pc_plus4;

    modport src (output reg_write, mem_write, result_sel, rd, alu_res, store_data, pc_plus4);
    modport dst (input reg_write, mem_write, result_sel, rd, alu_res, store_data, pc_plus4);
endinterface

//--- cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // RV32I major opcodes that this core understands
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;
    localparam logic [2:0] ALU_SLT = 3'd5;

    // Writeback source
    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;

    // One instruction word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_fmt;
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
    } inst_u;

endpackage

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage import cpu_pkg::*; (
    input  logic                  cpu_clk,
    input  logic                  rst_i,
    input  logic                  if_valid_i,
    input  logic [XLEN-1:0]       if_pc_i,
    input  logic [XLEN-1:0]       if_inst_i,
    input  logic                  flush_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic                  stall_o,
    id_ex_if.src                  id_ex
);

    inst_u           inst;
    logic [XLEN-1:0] rs1_data, rs2_data;
    logic [XLEN-1:0] imm_d;
    logic [2:0]      alu_op_d;
    logic [1:0]      result_sel_d;
    logic            alu_src_imm_d, reg_write_d, mem_write_d;
    logic            is_branch_d, branch_ne_d, is_jal_d;
    logic            use_rs1, use_rs2;
    logic            load_in_ex, kill;

    assign inst = if_inst_i;

    always_comb begin
        imm_d         = '0;
        alu_op_d      = ALU_ADD;
        result_sel_d  = RES_ALU;
        alu_src_imm_d = 1'b0;
        reg_write_d   = 1'b0;
        mem_write_d   = 1'b0;
        is_branch_d   = 1'b0;
        branch_ne_d   = inst.r_fmt.funct3[0];
        is_jal_d      = 1'b0;
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        case (inst.r_fmt.opcode)
            OP_R: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                reg_write_d = 1'b1;
                case (inst.r_fmt.funct3)
                    3'b000:  alu_op_d = inst.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op_d = ALU_SLT;
                    3'b100:  alu_op_d = ALU_XOR;
                    3'b110:  alu_op_d = ALU_OR;
                    3'b111:  alu_op_d = ALU_AND;
                    default: reg_write_d = 1'b0;    // Shifts and SLTU not built
                endcase
            end
            OP_IMM, OP_LOAD: begin
                use_rs1       = 1'b1;
                alu_src_imm_d = 1'b1;
                imm_d         = {{(XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                if (inst.r_fmt.opcode == OP_LOAD) begin
                    reg_write_d  = (inst.i_fmt.funct3 == 3'b010);    // LW only
                    result_sel_d = RES_MEM;
                end else begin
                    reg_write_d = (inst.i_fmt.funct3 == 3'b000);     // ADDI only
                end
            end
            OP_STORE: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                alu_src_imm_d = 1'b1;
                mem_write_d   = 1'b1;
                imm_d = {{(XLEN-12){if_inst_i[31]}}, if_inst_i[31:25], if_inst_i[11:7]};
            end
            OP_BRANCH: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                is_branch_d = (inst.r_fmt.funct3[2:1] == 2'b00);    // BEQ and BNE
                imm_d = {{(XLEN-12){if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                         if_inst_i[11:8], 1'b0};
            end
            OP_JAL: begin
                reg_write_d  = 1'b1;
                is_jal_d     = 1'b1;
                result_sel_d = RES_PC4;
                imm_d = {{(XLEN-20){if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                         if_inst_i[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    regfile regfile_inst (
        .cpu_clk    (cpu_clk),
        .rst_i      (rst_i),
        .rs1_i      (inst.r_fmt.rs1),
        .rs2_i      (inst.r_fmt.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_we_i),
        .rd_i       (wb_rd_i),
        .wd_i       (wb_data_i)
    );

    // A load in EX has no data yet for the instruction here
    assign load_in_ex = id_ex.valid && id_ex.reg_write && id_ex.result_sel == RES_MEM &&
                        id_ex.rd != '0;
    assign stall_o = if_valid_i && load_in_ex &&
                     ((use_rs1 && inst.r_fmt.rs1 == id_ex.rd) ||
                      (use_rs2 && inst.r_fmt.rs2 == id_ex.rd));
    assign kill = flush_i || stall_o || !if_valid_i;

    always_ff @(posedge cpu_clk) begin
        if (rst_i || kill) begin
            id_ex.valid     <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.is_branch <= 1'b0;
            id_ex.is_jal    <= 1'b0;
        end else begin
            id_ex.valid     <= 1'b1;
            id_ex.reg_write <= reg_write_d;
            id_ex.mem_write <= mem_write_d;
            id_ex.is_branch <= is_branch_d;
            id_ex.is_jal    <= is_jal_d;
        end
        id_ex.pc          <= if_pc_i;
        id_ex.pc_plus4    <= if_pc_i + XLEN'(4);
        id_ex.rs1         <= inst.r_fmt.rs1;
        id_ex.rs2         <= inst.r_fmt.rs2;
        id_ex.rd          <= inst.r_fmt.rd;
        id_ex.rs1_data    <= rs1_data;
        id_ex.rs2_data    <= rs2_data;
        id_ex.imm         <= imm_d;
        id_ex.alu_op      <= alu_op_d;
        id_ex.alu_src_imm <= alu_src_imm_d;
        id_ex.result_sel  <= result_sel_d;
        id_ex.branch_ne   <= branch_ne_d;
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage import cpu_pkg::*; (
    input  logic                  cpu_clk,
    input  logic                  rst_i,
    id_ex_if.dst                  id_ex,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirect_pc_o,
    ex_mem_if.src                 ex_mem
);

    logic                  mem_rw;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_val;
    logic [XLEN-1:0]       op_a, rs2_val, op_b, alu_res;
    logic                  operands_eq;

    assign mem_rw  = ex_mem.reg_write;
    assign mem_rd  = ex_mem.rd;
    assign mem_val = ex_mem.alu_res;

    // MEM has priority over WB and x0 is never forwarded
    function automatic logic [XLEN-1:0] fwd(input logic [REG_ADDR_W-1:0] rs,
                                            input logic [XLEN-1:0] id_val);
        if (rs != '0 && mem_rw && mem_rd == rs)
            return mem_val;
        if (rs != '0 && wb_we_i && wb_rd_i == rs)
            return wb_data_i;
        return id_val;
    endfunction

    always_comb begin
        op_a    = fwd(id_ex.rs1, id_ex.rs1_data);
        rs2_val = fwd(id_ex.rs2, id_ex.rs2_data);
    end

    assign op_b = id_ex.alu_src_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    assign operands_eq = (op_a == rs2_val);
    assign redirect_o = id_ex.valid &&
                        (id_ex.is_jal || (id_ex.is_branch && (operands_eq ^ id_ex.branch_ne)));
    assign redirect_pc_o = id_ex.pc + id_ex.imm;

    always_ff @(posedge cpu_clk) begin
        if (rst_i) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem.reg_write <= id_ex.reg_write;    // Already clear for bubbles
            ex_mem.mem_write <= id_ex.mem_write;
        end
        ex_mem.result_sel <= id_ex.result_sel;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.alu_res    <= alu_res;
        ex_mem.store_data <= rs2_val;
        ex_mem.pc_plus4   <= id_ex.pc_plus4;
    end

    // Decode flushes the slot behind a taken branch or jump
    a_redirect_flush: assert property (@(posedge cpu_clk) disable iff (rst_i)
        redirect_o |=> !id_ex.valid)
        else $error("execute_stage: entry behind a redirect was not flushed");

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage import cpu_pkg::*; (
    input  logic            cpu_clk,
    input  logic            rst_i,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    input  logic [XLEN-1:0] inst_i,
    output logic [XLEN-1:0] pc_o,
    output logic            if_valid_o,
    output logic [XLEN-1:0] if_pc_o,
    output logic [XLEN-1:0] if_inst_o
);

    always_ff @(posedge cpu_clk) begin
        if (rst_i) begin
            pc_o <= '0;
        end else if (redirect_i) begin
            pc_o <= redirect_pc_i;    // Redirect wins over a load-use hold
        end else if (!stall_i) begin
            pc_o <= pc_o + XLEN'(4);
        end
    end

    // IF/ID register
    always_ff @(posedge cpu_clk) begin
        if (rst_i || redirect_i) begin
            if_valid_o <= 1'b0;
        end else if (!stall_i) begin
            if_valid_o <= 1'b1;
        end
        if (!stall_i) begin
            if_pc_o   <= pc_o;
            if_inst_o <= inst_i;
        end
    end

    // Branch and jump targets come back from EX, so check them here
    a_pc_aligned: assert property (@(posedge cpu_clk) disable iff (rst_i)
        pc_o[1:0] == 2'b00)
        else $error("fetch_stage: misaligned pc %h", pc_o);

endmodule

//--- mem_wb_stage.sv
`timescale 1ns/1ns

module mem_wb_stage import cpu_pkg::*; (
    input  logic                  cpu_clk,
    input  logic                  rst_i,
    ex_mem_if.dst                 ex_mem,
    output logic [XLEN-1:0]       dmem_addr_o,
    output logic [XLEN-1:0]       dmem_wdata_o,
    output logic                  dmem_we_o,
    input  logic [XLEN-1:0]       dmem_rdata_i,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic [XLEN-1:0] alu_res_q, rdata_q, pc_plus4_q;
    logic [1:0]      result_sel_q;

    // Word-only access, one address for read and write
    assign dmem_addr_o  = ex_mem.alu_res;
    assign dmem_wdata_o = ex_mem.store_data;
    assign dmem_we_o    = ex_mem.mem_write;

    always_ff @(posedge cpu_clk) begin
        if (rst_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= ex_mem.reg_write;
        end
        wb_rd_o      <= ex_mem.rd;
        result_sel_q <= ex_mem.result_sel;
        alu_res_q    <= ex_mem.alu_res;
        rdata_q      <= dmem_rdata_i;    // Read data arrives in the MEM cycle
        pc_plus4_q   <= ex_mem.pc_plus4;
    end

    always_comb begin
        case (result_sel_q)
            RES_MEM: wb_data_o = rdata_q;
            RES_PC4: wb_data_o = pc_plus4_q;
            default: wb_data_o = alu_res_q;
        endcase
    end

    // Base register plus offset from EX must land on a word
    a_store_aligned: assert property (@(posedge cpu_clk) disable iff (rst_i)
        dmem_we_o |-> dmem_addr_o[1:0] == 2'b00)
        else $error("mem_wb_stage: misaligned store to %h", dmem_addr_o);

endmodule

//--- regfile.sv
`timescale 1ns/1ns

module regfile import cpu_pkg::*; (
    input  logic                  cpu_clk,
    input  logic                  rst_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [XLEN-1:0]       wd_i
);

    logic [XLEN-1:0] regs [32];

    // x0 reads zero, a same-cycle write shows through
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] ra);
        if (ra == '0)
            return '0;
        if (we_i && rd_i == ra)
            return wd_i;
        return regs[ra];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    always_ff @(posedge cpu_clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= wd_i;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_cpu_core \
    -Mdir obj_dir -o tb_cpu_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0

//--- tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// One instruction per step, straight from the RV32I encoding
logic [31:0] m_regs [32];
logic [31:0] m_mem [256];
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];

function automatic void set_reg(input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0)
        m_regs[rd] = val;
endfunction

task automatic model_run();
    logic [31:0] pc, next_pc, w, a, b, addr;
    logic [31:0] imm_i, imm_s, imm_b, imm_j;
    int          steps;
    for (int i = 0; i < 32; i++) m_regs[5'(i)] = '0;
    for (int i = 0; i < 256; i++) m_mem[8'(i)] = fill_word(i);
    exp_addr.delete();
    exp_data.delete();
    pc = '0;
    steps = 0;
    while (pc != halt_pc && steps < 4096) begin
        w       = imem[pc[9:2]];
        a       = m_regs[w[19:15]];
        b       = m_regs[w[24:20]];
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        next_pc = pc + 32'd4;
        case (w[6:0])
            7'b0110011:    // R-type
                case (w[14:12])
                    3'b000:  set_reg(w[11:7], w[30] ? a - b : a + b);
                    3'b010:  set_reg(w[11:7], {31'd0, $signed(a) < $signed(b)});
                    3'b100:  set_reg(w[11:7], a ^ b);
                    3'b110:  set_reg(w[11:7], a | b);
                    3'b111:  set_reg(w[11:7], a & b);
                    default: ;
                endcase
            7'b0010011: set_reg(w[11:7], a + imm_i);    // ADDI
            7'b0000011: begin
                addr = a + imm_i;
                set_reg(w[11:7], m_mem[addr[9:2]]);
            end
            7'b0100011: begin
                addr = a + imm_s;
                m_mem[addr[9:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            7'b1100011: if ((a == b) != w[12]) next_pc = pc + imm_b;    // funct3 bit 0 picks BNE
            7'b1101111: begin
                set_reg(w[11:7], pc + 32'd4);
                next_pc = pc + imm_j;
            end
            default: ;
        endcase
        pc = next_pc;
        steps++;
    end
    assert (pc == halt_pc) else begin
        $display("The reference model never reached the halt address");
        errors++;
    end
endtask

`endif

//--- tb_cpu_core.sv
`timescale 1ns/1ns

module tb_cpu_core import cpu_pkg::*; ();

    logic            cpu_clk = 1'b0;
    logic            rst_i = 1'b1;
    logic [XLEN-1:0] pc_o, inst_i, dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    logic            dmem_we_o;

    logic [31:0] prog [256];    // Program being built, copied into imem under reset
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] obs_addr [$];
    logic [31:0] obs_data [$];
    logic [31:0] halt_pc;
    int          plen;
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    integer      seed = 32'h11e8;

    always #4 cpu_clk = ~cpu_clk;

    cpu_core cpu_core_inst (
        .cpu_clk      (cpu_clk),
        .rst_i        (rst_i),
        .pc_o         (pc_o),
        .inst_i       (inst_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i)
    );

    assign inst_i       = imem[pc_o[9:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];

    // Every word differs, so a load from a wrong address shows up
    function automatic logic [31:0] fill_word(input int i);
        return 32'ha5a5_0000 ^ (32'(i) * 32'h0001_0003);
    endfunction

    always @(posedge cpu_clk) begin
        if (rst_i) begin
            for (int i = 0; i < 256; i++) dmem[8'(i)] <= fill_word(i);
            obs_addr.delete();
            obs_data.delete();
        end else if (dmem_we_o) begin
            dmem[dmem_addr_o[9:2]] <= dmem_wdata_o;
            obs_addr.push_back(dmem_addr_o);
            obs_data.push_back(dmem_wdata_o);
        end
    end

    `include "tb_ref_model.svh"

    function automatic logic [31:0] pick(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // f3 000 with sub set gives SUB
    function automatic logic [31:0] r_op(input logic [2:0] f3, input logic sub,
                                         input int rd, input int rs1, input int rs2);
        return {1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] br(input int ne, input int rs1, input int rs2, input int off);
        logic [12:0] im;
        im = 13'(off);
        return {im[12], im[10:5], 5'(rs2), 5'(rs1), 2'b00, 1'(ne), im[4:1], im[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int off);
        logic [20:0] im;
        im = 21'(off);
        return {im[20], im[10:1], im[11], im[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic start_program();
        plen = 0;
        for (int i = 0; i < 256; i++) prog[8'(i)] = 32'h0000_0013;    // NOP
    endtask

    task automatic emit(input logic [31:0] w);
        prog[8'(plen)] = w;
        plen++;
    endtask

    task automatic end_program();
        halt_pc = 32'(plen) * 4;
        emit(jal(0, 0));    // Jump to itself
    endtask

    task automatic straight_line_program();
        start_program();
        emit(addi(1, 0, 11));
        emit(addi(2, 0, -7));
        emit(addi(10, 0, 'h20));
        emit(addi(3, 0, 100));
        emit(sw(1, 10, 0));
        emit(sw(2, 10, 4));
        end_program();
    endtask

    task automatic forwarding_program();
        start_program();
        emit(addi(10, 0, 'h100));
        emit(addi(1, 0, 5));
        emit(addi(2, 1, 7));                     // x1 from MEM
        emit(r_op(3'b000, 1'b0, 3, 1, 2));       // x1 from WB, x2 from MEM
        emit(r_op(3'b000, 1'b1, 4, 3, 1));
        emit(r_op(3'b100, 1'b0, 5, 4, 3));
        emit(r_op(3'b111, 1'b0, 6, 5, 2));
        emit(r_op(3'b110, 1'b0, 7, 6, 4));
        emit(r_op(3'b010, 1'b0, 8, 4, 7));
        for (int r = 1; r <= 8; r++) emit(sw(r, 10, 4 * r));
        end_program();
    endtask

    task automatic load_use_program();
        start_program();
        emit(addi(10, 0, 'h80));
        emit(addi(1, 0, -300));
        emit(sw(1, 10, 0));
        emit(lw(2, 10, 0));
        emit(r_op(3'b000, 1'b0, 3, 2, 1));    // Needs the load right away
        emit(sw(3, 10, 4));
        emit(lw(4, 10, 8));
        emit(sw(4, 10, 12));                  // Store data from the load
        end_program();
    endtask

    task automatic control_flow_program();
        start_program();
        emit(addi(1, 0, 3));
        emit(addi(2, 0, 3));
        emit(addi(10, 0, 'h40));
        emit(br(0, 1, 2, 12));    // BEQ taken
        emit(sw(1, 10, 0));
        emit(sw(2, 10, 4));
        emit(br(1, 1, 2, 8));     // BNE not taken
        emit(sw(1, 10, 8));
        emit(br(0, 1, 0, 8));     // BEQ not taken
        emit(sw(2, 10, 12));
        emit(br(1, 1, 0, 12));    // BNE taken
        emit(sw(1, 10, 16));
        emit(sw(1, 10, 20));
        emit(jal(5, 12));         // Link is 13 * 4 + 4
        emit(sw(2, 10, 24));
        emit(sw(2, 10, 28));
        emit(sw(5, 10, 32));
        end_program();
    endtask

    task automatic zero_reg_program();
        start_program();
        emit(addi(10, 0, 'h60));
        emit(addi(0, 0, 55));
        emit(sw(0, 10, 0));
        emit(r_op(3'b000, 1'b0, 0, 10, 10));
        emit(sw(0, 10, 4));
        emit(lw(0, 10, 32));
        emit(sw(0, 10, 8));
        end_program();
    endtask

    // x31 stays the word-aligned base, branches only go forward
    task automatic random_program();
        int rd, rs1, rs2, k;
        start_program();
        emit(addi(31, 0, 'h200));
        for (int r = 1; r < 8; r++) emit(addi(r, 0, pick(4096) - 2048));
        for (int i = 0; i < 60; i++) begin
            rd  = pick(31);
            rs1 = pick(32);
            rs2 = pick(32);
            k   = 1 + pick(4);
            if (k > 60 - i)
                k = 60 - i;
            case (pick(11))
                0:       emit(r_op(3'b000, 1'b0, rd, rs1, rs2));
                1:       emit(r_op(3'b000, 1'b1, rd, rs1, rs2));
                2:       emit(r_op(3'b111, 1'b0, rd, rs1, rs2));
                3:       emit(r_op(3'b110, 1'b0, rd, rs1, rs2));
                4:       emit(r_op(3'b100, 1'b0, rd, rs1, rs2));
                5:       emit(r_op(3'b010, 1'b0, rd, rs1, rs2));
                6:       emit(addi(rd, rs1, pick(4096) - 2048));
                7:       emit(lw(rd, 31, 4 * (pick(64) - 32)));
                8:       emit(sw(rs2, 31, 4 * (pick(64) - 32)));
                9:       emit(br(pick(2), rs1, rs2, 4 * k));
                default: emit(jal(rd, 4 * k));
            endcase
        end
        for (int r = 1; r < 32; r++) emit(sw(r, 31, 4 * r));    // Final registers
        end_program();
    endtask

    task automatic compare_stores();
        assert (obs_addr.size() == exp_addr.size()) else begin
            $display("The core made %0d stores where %0d were expected",
                     obs_addr.size(), exp_addr.size());
            errors++;
        end
        for (int i = 0; i < obs_addr.size() && i < exp_addr.size(); i++) begin
            assert (obs_addr[i] == exp_addr[i]) else begin
                $display("Fail dmem_addr_o store %0d: got %h expected %h",
                         i, obs_addr[i], exp_addr[i]);
                errors++;
            end
            assert (obs_data[i] == exp_data[i]) else begin
                $display("Fail dmem_wdata_o store %0d: got %h expected %h",
                         i, obs_data[i], exp_data[i]);
                errors++;
            end
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        int errs_before;
        errs_before = errors;
        rst_i = 1'b1;
        for (int c = 0; c < 3; c++) begin
            @(posedge cpu_clk);
            #1;
            assert (pc_o == '0 && dmem_we_o == 1'b0) else begin
                $display("Fail pc_o %h dmem_we_o %h during reset, expected 0", pc_o, dmem_we_o);
                errors++;
            end
        end
        for (int i = 0; i < 256; i++) imem[8'(i)] = prog[8'(i)];
        model_run();
        rst_i = 1'b0;
        for (int c = 1; c <= 3; c++) begin
            @(posedge cpu_clk);
            #1;
            assert (pc_o == 4 * c) else begin
                $display("Fail pc_o after reset: got %h expected %h", pc_o, 4 * c);
                errors++;
            end
        end
        cycles = 0;
        while (pc_o != halt_pc && cycles < 2000) begin
            @(posedge cpu_clk);
            #1;
            cycles++;
        end
        assert (pc_o == halt_pc) else begin
            $display("%s: the core did not reach the halt address in 2000 cycles", name);
            errors++;
        end
        repeat (10) begin
            @(posedge cpu_clk);
            #1;
        end
        compare_stores();
        tests++;
        if (errors != errs_before)
            failed++;
        $display("Test %0d %s: %s", tests, name, (errors == errs_before) ? "passed" : "failed");
    endtask

    initial begin
        for (int i = 0; i < 256; i++) imem[8'(i)] = 32'h0000_0013;
        straight_line_program();
        run_program("reset and straight line");
        forwarding_program();
        run_program("forwarding");
        load_use_program();
        run_program("load-use");
        control_flow_program();
        run_program("control flow");
        zero_reg_program();
        run_program("x0");
        for (int n = 1; n <= 5; n++) begin
            random_program();
            run_program($sformatf("random %0d", n));
        end
        $display("Tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
